//--- list.f
source/rom_core_pkg.sv
source/frac_cen.sv
source/prog_loader.sv
source/prom_table.sv
source/rom_slot.sv
source/rom_core_top.sv
verification/sdram_model.sv
verification/rom_core_tb.sv

//--- source/frac_cen.sv
// Expects 0 < num <= den; enables are one clk wide and start from reset with an empty accumulator
module frac_cen #(
    parameter int num = 1,
    parameter int den = 2
) (
    input  logic clk,
    input  logic rst_n,
    output logic cen,
    output logic cen_half
);

    localparam int aw = $clog2(num + den) + 1;
    localparam logic [aw-1:0] num_w = aw'(num);
    localparam logic [aw-1:0] den_w = aw'(den);

    logic [aw-1:0] acc;
    logic [aw-1:0] sum;
    logic          wrap;    // Accumulator crossed den this cycle
    logic          toggle;  // High after an odd number of enables

    assign sum  = acc + num_w;
    assign wrap = sum >= den_w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            cen      <= 1'b0;
            cen_half <= 1'b0;
            toggle   <= 1'b0;
        end else begin
            acc      <= wrap ? sum - den_w : sum;
            cen      <= wrap;
            cen_half <= wrap & toggle;  // Second, fourth, ... enable
            if (wrap) begin
                toggle <= ~toggle;
            end
        end
    end

endmodule

//--- source/prog_loader.sv
// Writes outside the map are dropped; the core reset is held for the whole download
module prog_loader
    import rom_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    output prog_t       prog,
    output logic        prog_we,
    output logic        pal_we,
    output logic        timing_we,
    output logic [7:0]  prom_addr,
    output logic [7:0]  prom_data,
    output logic        encrypted,
    output logic        core_rst_n
);

    logic       in_main;
    logic       in_pal;
    logic       in_timing;
    logic       in_crypt;
    logic [1:0] rst_sr;     // Release shift register

    // Address decode against the download map
    assign in_main   = (ioctl_addr >= main_base) && (ioctl_addr <= main_last);
    assign in_pal    = (ioctl_addr >= pal_base)
                    && (ioctl_addr < pal_base + 22'(pal_depth));
    assign in_timing = (ioctl_addr >= timing_base)
                    && (ioctl_addr < timing_base + 22'(timing_depth));
    assign in_crypt  = ioctl_addr == crypt_addr;

    // Strobes and flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we   <= 1'b0;
            pal_we    <= 1'b0;
            timing_we <= 1'b0;
            encrypted <= 1'b0;
        end else begin
            prog_we   <= ioctl_wr & in_main;
            pal_we    <= ioctl_wr & in_pal;
            timing_we <= ioctl_wr & in_timing;
            if (ioctl_wr && in_crypt) begin
                encrypted <= ioctl_data[0];
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (ioctl_wr && in_main) begin
            prog.addr <= ioctl_addr >> 1;
            prog.data <= ioctl_data;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte is the upper lane
        end
        if (ioctl_wr && (in_pal || in_timing)) begin
            prom_addr <= ioctl_addr[7:0];  // Both PROM bases sit on 256-byte boundaries
            prom_data <= ioctl_data;
        end
    end

    // Two-stage release once the download is over
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sr <= 2'b00;
        end else if (downloading) begin
            rst_sr <= 2'b00;
        end else begin
            rst_sr <= {rst_sr[0], 1'b1};
        end
    end

    assign core_rst_n = rst_sr[1] & ~downloading;  // Drops as soon as a download starts

endmodule

//--- source/prom_table.sv
// Contents are undefined until written; no reset, the read port always lags raddr by one clk
module prom_table #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 32
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [depth];  // Maps to block or distributed RAM

    // Download side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Video side read
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- source/rom_core_pkg.sv
// Address map assumes a download image of at most 0x8201 bytes; SDRAM words are 32 bits wide
package rom_core_pkg;

    // Download byte map
    localparam logic [21:0] main_base   = 22'h00_0000;
    localparam logic [21:0] main_last   = 22'h00_7FFF;  // 32 kB CPU ROM
    localparam logic [21:0] pal_base    = 22'h00_8000;
    localparam logic [21:0] timing_base = 22'h00_8100;
    localparam logic [21:0] crypt_addr  = 22'h00_8200;  // Bit 0 flags an encrypted set

    localparam int pal_depth    = 32;
    localparam int timing_depth = 256;

    // Colour PROM entry, red sits in the low bits
    typedef struct packed {
        logic [2:0] blue;
        logic [2:0] green;
        logic [2:0] red;
    } pal_entry_t;

    // Timing PROM entry, hblank is bit 0
    typedef struct packed {
        logic [1:0] phase;
        logic       vblank;
        logic       hblank;
    } timing_entry_t;

    // Word address counted in 32-bit units
    typedef struct packed {
        logic [21:0] addr;
        logic [1:0]  tag;
    } sdram_req_t;

    // Tag echoes the request it answers
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  tag;
    } sdram_rsp_t;

    // SDRAM programming write
    typedef struct packed {
        logic [21:0] addr;  // 16-bit word address
        logic [7:0]  data;
        logic [1:0]  mask;  // Active low, selects the byte lane
    } prog_t;

endpackage

//--- source/rom_core_top.sv
// Single clock domain; palette blue MSB loads as zero since PROM bytes are 8 bits wide
module rom_core_top
    import rom_core_pkg::*;
#(
    parameter int          sdram_credits = 2,
    parameter int unsigned rom_offset    = 0,
    parameter int          pxl_num       = 21,
    parameter int          pxl_den       = 50,
    parameter int          cpu_num       = 1,
    parameter int          cpu_den       = 12
) (
    input  logic          clk,
    input  logic          rst_n,
    // Download
    input  logic          downloading,
    input  logic          ioctl_wr,
    input  logic [21:0]   ioctl_addr,
    input  logic [7:0]    ioctl_data,
    output prog_t         prog,
    output logic          prog_we,
    // CPU ROM
    input  logic          rom_cs,
    input  logic [14:0]   rom_addr,
    output logic          rom_ok,
    output logic [7:0]    rom_data,
    // SDRAM
    output logic          req_valid,
    output sdram_req_t    req,
    input  logic          rsp_valid,
    input  sdram_rsp_t    rsp,
    // PROM reads
    input  logic [4:0]    pal_raddr,
    output pal_entry_t    pal_rdata,
    input  logic [7:0]    timing_raddr,
    output timing_entry_t timing_rdata,
    output logic          encrypted,
    output logic          core_rst_n,
    // Clock enables
    output logic          pxl_cen,
    output logic          pxl2_cen,
    output logic          cpu_cen,
    output logic          ay_cen
);

    logic       pal_we;
    logic       timing_we;
    logic [7:0] prom_addr;
    logic [7:0] prom_data;

    prog_loader u_loader (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .pal_we      ( pal_we      ),
        .timing_we   ( timing_we   ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .encrypted   ( encrypted   ),
        .core_rst_n  ( core_rst_n  )
    );

    frac_cen #(.num(pxl_num), .den(pxl_den)) u_cen_pxl (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( pxl_cen  ),     // Base pixel rate
        .cen_half ( pxl2_cen )
    );

    frac_cen #(.num(cpu_num), .den(cpu_den)) u_cen_cpu (
        .clk      ( clk     ),
        .rst_n    ( rst_n   ),
        .cen      ( cpu_cen ),
        .cen_half ( ay_cen  )       // PSG runs at half the CPU rate
    );

    prom_table #(.entry_t(pal_entry_t), .depth(pal_depth)) u_pal (
        .clk   ( clk                             ),
        .we    ( pal_we                          ),
        .waddr ( prom_addr[4:0]                  ),
        .wdata ( pal_entry_t'({1'b0, prom_data}) ),
        .raddr ( pal_raddr                       ),
        .rdata ( pal_rdata                       )
    );

    prom_table #(.entry_t(timing_entry_t), .depth(timing_depth)) u_timing (
        .clk   ( clk                             ),
        .we    ( timing_we                       ),
        .waddr ( prom_addr                       ),
        .wdata ( timing_entry_t'(prom_data[3:0]) ),
        .raddr ( timing_raddr                    ),
        .rdata ( timing_rdata                    )
    );

    rom_slot #(.sdram_credits(sdram_credits), .rom_offset(rom_offset)) u_slot (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .core_rst_n ( core_rst_n ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_ok     ( rom_ok     ),
        .rom_data   ( rom_data   ),
        .req_valid  ( req_valid  ),
        .req        ( req        ),
        .rsp_valid  ( rsp_valid  ),
        .rsp        ( rsp        )
    );

endmodule

//--- source/rom_slot.sv
// Assumes the SDRAM answers every request once; stale data is discarded only via core_rst_n
module rom_slot
    import rom_core_pkg::*;
#(
    parameter int          sdram_credits = 2,
    parameter int unsigned rom_offset    = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_rst_n,
    input  logic        rom_cs,
    input  logic [14:0] rom_addr,
    output logic        rom_ok,
    output logic [7:0]  rom_data,
    output logic        req_valid,
    output sdram_req_t  req,
    input  logic        rsp_valid,
    input  sdram_rsp_t  rsp
);

    localparam int cw = $clog2(sdram_credits + 1);

    logic [cw-1:0] credits;
    logic [1:0]    line_valid;
    logic [1:0]    line_pend;
    logic [12:0]   line_addr [2];
    logic [31:0]   line_data [2];
    logic          mru;             // Line hit most recently

    logic [12:0] word;
    logic [12:0] next_word;
    logic [1:0]  hit;
    logic [1:0]  pmatch;
    logic [1:0]  nhas;
    logic        hit_idx;
    logic        dem_res;
    logic        dem_idx;
    logic        victim;
    logic        can_issue;
    logic        miss_req;
    logic        pf_req;
    logic        issue;
    logic        issue_idx;
    logic [12:0] issue_word;
    logic        ok_q;
    logic [14:0] addr_q;

    assign word      = rom_addr[14:2];
    assign next_word = word + 13'd1;

    // Tag compare on both lines
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]    = line_valid[i] && (line_addr[i] == word);
            pmatch[i] = line_pend[i] && (line_addr[i] == word);
            nhas[i]   = (line_valid[i] || line_pend[i]) && (line_addr[i] == next_word);
        end
    end

    assign hit_idx = hit[1];
    assign dem_res = |(hit | pmatch);   // Demand word present or on its way
    assign dem_idx = hit[1] | pmatch[1];

    // Replace a line with nothing in flight, the older one if both are free
    assign victim = (line_pend == 2'b00) ? ~mru : line_pend[0];

    assign can_issue  = core_rst_n && rom_cs && (credits != '0);
    assign miss_req   = can_issue && !dem_res && (line_pend != 2'b11);
    assign pf_req     = can_issue && dem_res && (nhas == 2'b00) && !line_pend[~dem_idx];
    assign issue      = miss_req | pf_req;
    assign issue_idx  = miss_req ? victim : ~dem_idx;
    assign issue_word = miss_req ? word : next_word;

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits    <= cw'(sdram_credits);
            line_valid <= 2'b00;
            line_pend  <= 2'b00;
            mru        <= 1'b0;
            req_valid  <= 1'b0;
            ok_q       <= 1'b0;
        end else begin
            case ({issue, rsp_valid})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (rsp_valid) begin
                line_pend[rsp.tag[0]]  <= 1'b0;
                line_valid[rsp.tag[0]] <= 1'b1;
            end
            if (issue) begin
                line_pend[issue_idx]  <= 1'b1;
                line_valid[issue_idx] <= 1'b0;
            end
            if (!core_rst_n) begin
                line_valid <= 2'b00;    // Flush, pending replies still return credits
            end
            if (rom_cs && (hit != 2'b00)) begin
                mru <= hit_idx;
            end
            req_valid <= issue;
            ok_q      <= rom_cs && (hit != 2'b00);
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (issue) begin
            line_addr[issue_idx] <= issue_word;
            req.addr             <= 22'(rom_offset) + {9'd0, issue_word};
            req.tag              <= {1'b0, issue_idx};
        end
        if (rsp_valid) begin
            line_data[rsp.tag[0]] <= rsp.data;
        end
        rom_data <= line_data[hit_idx][{rom_addr[1:0], 3'b000} +: 8];  // Little endian
        addr_q   <= rom_addr;
    end

    // Only valid for the address it was looked up with
    assign rom_ok = ok_q & rom_cs & (rom_addr == addr_q);

endmodule

//--- verification/rom_core_tb.sv
// Assumes default top-level parameters with rom_offset 0; the download starts at power-up
module rom_core_tb
    import rom_core_pkg::*;
();

    localparam int sdram_credits = 2;
    localparam int rom_timeout   = 100;    // Cycles per ROM read

    logic          clk;
    logic          rst_n;
    logic          downloading;
    logic          ioctl_wr;
    logic [21:0]   ioctl_addr;
    logic [7:0]    ioctl_data;
    prog_t         prog;
    logic          prog_we;
    logic          rom_cs;
    logic [14:0]   rom_addr;
    logic          rom_ok;
    logic [7:0]    rom_data;
    logic          req_valid;
    sdram_req_t    req;
    logic          rsp_valid;
    sdram_rsp_t    rsp;
    logic [4:0]    pal_raddr;
    pal_entry_t    pal_rdata;
    logic [7:0]    timing_raddr;
    timing_entry_t timing_rdata;
    logic          encrypted;
    logic          core_rst_n;
    logic          pxl_cen, pxl2_cen, cpu_cen, ay_cen;
    int            max_outstanding;    // Peak requests in flight seen by the model

    int            check_count, error_count, timeout_count;
    int            pxl_count, pxl2_count, cpu_count, ay_count;
    int            waited;
    pal_entry_t    exp_pal;
    timing_entry_t exp_timing;

    // Main ROM bytes with the expected byte-lane mask
    logic [21:0] main_addr [6] = '{22'h0000, 22'h0001, 22'h1234, 22'h2345, 22'h7FFE, 22'h7FFF};
    logic [7:0]  main_data [6] = '{8'h12, 8'hA5, 8'h00, 8'hFF, 8'h3C, 8'hC3};
    logic [1:0]  main_mask [6] = '{2'b10, 2'b01, 2'b10, 2'b01, 2'b10, 2'b01};
    // Palette entries first and timing after
    logic [21:0] prom_addr [8] = '{22'h8000, 22'h8001, 22'h8010, 22'h801F,
                                   22'h8100, 22'h8101, 22'h8180, 22'h81FF};
    logic [7:0]  prom_data [8] = '{8'hA5, 8'h3C, 8'h47, 8'hFF, 8'h0D, 8'h02, 8'hF6, 8'h0F};
    // Flag writes and the flag value expected afterwards
    logic [21:0] flag_addr [6] = '{22'h8200, 22'h8201, 22'h0010, 22'h8200, 22'h8105, 22'h8200};
    logic [7:0]  flag_data [6] = '{8'h01, 8'h00, 8'h00, 8'hFE, 8'h01, 8'h03};
    logic        flag_exp  [6] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    // Sequential runs, the top word and jumps back
    logic [14:0] rom_seq [16] = '{15'h0000, 15'h0001, 15'h0002, 15'h0003, 15'h0004, 15'h0006,
                                  15'h0009, 15'h000C, 15'h1234, 15'h1235, 15'h7FFF, 15'h7FFC,
                                  15'h0003, 15'h4000, 15'h4005, 15'h2AAA};

    rom_core_top #(.sdram_credits(sdram_credits)) i_rom_core_top (.*);

    sdram_model u_sdram (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Returns on the negedge where the registered outputs show the write
    task automatic download_byte(input logic [21:0] addr, input logic [7:0] data);
        ioctl_wr   = 1'b1;
        ioctl_addr = addr;
        ioctl_data = data;
        @(negedge clk);
        ioctl_wr = 1'b0;
        compare(core_rst_n, 1'b0, "core reset held during download");
    endtask

    // Model word is its address XOR 0x5A5A0000 with bytes in little-endian order
    function automatic logic [7:0] rom_byte(input logic [14:0] addr);
        logic [31:0] word;
        word = {19'd0, addr[14:2]} ^ 32'h5A5A_0000;
        return word[8 * addr[1:0] +: 8];
    endfunction

    initial begin
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        rst_n         = 1'b0;
        downloading   = 1'b1;
        ioctl_wr      = 1'b0;
        ioctl_addr    = '0;
        ioctl_data    = '0;
        rom_cs        = 1'b0;
        rom_addr      = '0;
        pal_raddr     = '0;
        timing_raddr  = '0;
        repeat (5) @(negedge clk);
        compare({prog_we, req_valid, rom_ok, pxl_cen, pxl2_cen, cpu_cen, ay_cen}, 32'd0,
                "strobes low in reset");
        rst_n = 1'b1;

        // Enable counts over the first den cycles
        pxl_count  = 0;
        pxl2_count = 0;
        cpu_count  = 0;
        ay_count   = 0;
        for (int k = 0; k < 50; k++) begin
            @(negedge clk);
            pxl_count  += pxl_cen;
            pxl2_count += pxl2_cen;
            ay_count   += ay_cen;
            if (k < 12) begin
                cpu_count += cpu_cen;
            end
        end
        compare(pxl_count, 21, "pxl_cen pulses in 50 cycles");
        compare(pxl2_count, 10, "pxl2_cen pulses in 50 cycles");
        compare(cpu_count, 1, "cpu_cen pulses in 12 cycles");
        // Four CPU enables in 50 cycles, every second one halved
        compare(ay_count, 2, "ay_cen pulses in 50 cycles");

        for (int i = 0; i < 6; i++) begin
            download_byte(main_addr[i], main_data[i]);
            compare(prog_we, 1'b1, "prog_we after main write");
            compare(prog, {main_addr[i] >> 1, main_data[i], main_mask[i]}, "prog fields");
            @(negedge clk);
            compare(prog_we, 1'b0, "prog_we one cycle wide");
        end
        for (int i = 0; i < 8; i++) begin
            download_byte(prom_addr[i], prom_data[i]);
            compare(prog_we, 1'b0, "no prog_we for a PROM write");
        end
        for (int i = 0; i < 6; i++) begin
            download_byte(flag_addr[i], flag_data[i]);
            compare(encrypted, flag_exp[i], "encrypted flag");
        end

        // Release takes two clk
        @(negedge clk);
        downloading = 1'b0;
        @(negedge clk);
        compare(core_rst_n, 1'b0, "core reset one cycle after download");
        @(negedge clk);
        compare(core_rst_n, 1'b1, "core reset released on second cycle");

        for (int i = 0; i < 8; i++) begin
            pal_raddr    = 5'(prom_addr[i] - pal_base);
            timing_raddr = 8'(prom_addr[i] - timing_base);
            @(negedge clk);
            if (prom_addr[i] < timing_base) begin
                exp_pal.red   = prom_data[i][2:0];
                exp_pal.green = prom_data[i][5:3];
                exp_pal.blue  = {1'b0, prom_data[i][7:6]};  // Byte has no ninth bit
                compare(pal_rdata, exp_pal, "palette entry");
            end else begin
                exp_timing.hblank = prom_data[i][0];
                exp_timing.vblank = prom_data[i][1];
                exp_timing.phase  = prom_data[i][3:2];
                compare(timing_rdata, exp_timing, "timing entry");
            end
        end

        rom_cs = 1'b1;
        for (int i = 0; i < 16; i++) begin
            rom_addr = rom_seq[i];
            waited   = 0;
            @(negedge clk);
            while (!rom_ok && waited < rom_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (rom_ok) begin
                compare(rom_data, rom_byte(rom_seq[i]), "ROM byte");
            end else begin
                timeout_count++;
                $display("Timeout: no rom_ok for ROM address %h within %0d cycles",
                         rom_seq[i], rom_timeout);
            end
        end
        rom_cs = 1'b0;
        repeat (8) @(negedge clk);     // Prefetch replies drain
        compare(max_outstanding <= sdram_credits, 1'b1, "SDRAM requests within credits");

        $display("Summary: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verification/sdram_model.sv
// Simulation only; data is word address XOR 0x5A5A0000, one reply per clk after 1 to 4 clk
module sdram_model
    import rom_core_pkg::*;
(
    input  logic       clk,
    input  logic       req_valid,
    input  sdram_req_t req,
    output logic       rsp_valid,
    output sdram_rsp_t rsp,
    output int         max_outstanding
);

    localparam int depth = 4;

    sdram_req_t  pend_req  [depth];
    int          pend_wait [depth];    // Negedges left before the reply
    logic        pend_busy [depth];
    logic [31:0] seed;
    int          outstanding;
    int          pick;
    int          free_idx;

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        seed            = 32'h86d1fd97;
        outstanding     = 0;
        max_outstanding = 0;
        rsp_valid       = 1'b0;
        rsp             = '0;
        for (int i = 0; i < depth; i++) begin
            pend_busy[i] = 1'b0;
        end
        forever begin
            @(negedge clk);
            rsp_valid = 1'b0;
            pick      = -1;
            free_idx  = -1;
            for (int i = 0; i < depth; i++) begin
                if (pend_busy[i] && pend_wait[i] > 0) begin
                    pend_wait[i]--;
                end else if (pend_busy[i] && pick < 0) begin
                    pick = i;   // A short latency overtakes an older request
                end
            end
            if (pick >= 0) begin
                rsp_valid       = 1'b1;
                rsp.data        = {10'd0, pend_req[pick].addr} ^ 32'h5A5A_0000;
                rsp.tag         = pend_req[pick].tag;
                pend_busy[pick] = 1'b0;
                outstanding--;
            end
            if (req_valid) begin
                for (int i = depth - 1; i >= 0; i--) begin
                    if (!pend_busy[i]) begin
                        free_idx = i;
                    end
                end
                seed = lcg_next(seed);
                outstanding++;     // Overflow still shows in the peak
                if (outstanding > max_outstanding) begin
                    max_outstanding = outstanding;
                end
                if (free_idx >= 0) begin
                    pend_req[free_idx]  = req;
                    pend_wait[free_idx] = int'(seed[17:16]);
                    pend_busy[free_idx] = 1'b1;
                end
            end
        end
    end

endmodule
